//--- Makefile
TOP := tbMipsCore

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
src/mipsPkg.sv
src/ctrlDecode.sv
src/regFile.sv
src/aluUnit.sv
src/nextPc.sv
src/dataMem.sv
src/mipsCore.sv
verif/mipsCore_sva.sv
verif/tbMipsCore.sv

//--- src/aluUnit.sv
`timescale 1ns/100ps

module aluUnit (
	input  mipsPkg::ctrlT ctrl,
	input  logic [31:0]   rsData,
	input  logic [31:0]   rtData,
	input  logic [15:0]   imm16,
	output logic [31:0]   aluY
);

	logic [31:0] extImm; // Extended immediate
	logic [31:0] opB;    // Second ALU operand

	//////////////////////////////
	// Immediate extension
	//////////////////////////////
	always_comb begin
		if (ctrl.extSigned) begin
			extImm = {{16{imm16[15]}}, imm16}; // lw, sw offsets
		end else begin
			extImm = {16'h0000, imm16};        // ori, lui
		end
	end

	assign opB = ctrl.aluSrcImm ? extImm : rtData;

	//////////////////////////////
	// Operations
	//////////////////////////////
	always_comb begin
		case (ctrl.aluOp)
			mipsPkg::aluAdd: aluY = rsData + opB; // Wraps, no overflow trap
			mipsPkg::aluSub: aluY = rsData - opB;
			mipsPkg::aluOr:  aluY = rsData | opB;
			mipsPkg::aluLui: aluY = {opB[15:0], 16'h0000}; // Upper half load
			default:         aluY = rsData + opB;
		endcase
	end

endmodule

//--- src/ctrlDecode.sv
`timescale 1ns/100ps

module ctrlDecode (
	input  logic [31:0]   instr,
	input  logic          judge, // rs negative, from nextPc
	output mipsPkg::ctrlT ctrl
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	//////////////////////////////
	// Opcode and function match
	//////////////////////////////
	always_comb begin
		// Inactive defaults, anything unmatched is a nop
		ctrl.regDst    = mipsPkg::dstRt;
		ctrl.regWrite  = 1'b0;
		ctrl.extSigned = 1'b0;
		ctrl.aluSrcImm = 1'b0;
		ctrl.aluOp     = mipsPkg::aluAdd;
		ctrl.memWrite  = 1'b0;
		ctrl.wbSel     = mipsPkg::wbAlu;
		ctrl.npcOp     = mipsPkg::npcSeq;

		case (opcode)
			mipsPkg::opRType: begin
				case (funct)
					mipsPkg::fnAdd: begin
						ctrl.regDst   = mipsPkg::dstRd;
						ctrl.regWrite = 1'b1;
					end
					mipsPkg::fnSub: begin
						ctrl.regDst   = mipsPkg::dstRd;
						ctrl.regWrite = 1'b1;
						ctrl.aluOp    = mipsPkg::aluSub;
					end
					mipsPkg::fnJr: ctrl.npcOp = mipsPkg::npcJr; // Jump to rs
					default: ;                                  // Unknown funct
				endcase
			end
			mipsPkg::opOri: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1; // Zero extended
				ctrl.aluOp     = mipsPkg::aluOr;
			end
			mipsPkg::opLw: begin
				ctrl.regWrite  = 1'b1;
				ctrl.extSigned = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.wbSel     = mipsPkg::wbMem; // Load data to rt
			end
			mipsPkg::opSw: begin
				ctrl.extSigned = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite  = 1'b1;
			end
			mipsPkg::opBeq: ctrl.npcOp = mipsPkg::npcBeq; // Compare lives in nextPc
			mipsPkg::opLui: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp     = mipsPkg::aluLui;
			end
			mipsPkg::opJ: ctrl.npcOp = mipsPkg::npcJump;
			mipsPkg::opJal: begin
				ctrl.regDst   = mipsPkg::dstLink;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel    = mipsPkg::wbLink;
				ctrl.npcOp    = mipsPkg::npcJump;
			end
			mipsPkg::opBltzal: begin
				// Link only when the branch is taken
				ctrl.regDst   = mipsPkg::dstLink;
				ctrl.regWrite = judge;
				ctrl.wbSel    = mipsPkg::wbLink;
				ctrl.npcOp    = mipsPkg::npcBltzal;
			end
			default: ; // Undefined opcode
		endcase
	end

endmodule

//--- src/dataMem.sv
`timescale 1ns/100ps

module dataMem (
	input  logic        clk,
	input  logic        arstN,
	input  logic [31:0] addr,   // Byte address
	input  logic [31:0] wrData,
	input  logic        wrEn,
	output logic [31:0] rdData
);

	logic [31:0] mem [mipsPkg::dmemWords];
	logic [$clog2(mipsPkg::dmemWords)-1:0] wordIdx;

	// Word index from byte address, low two bits dropped
	assign wordIdx = addr[$clog2(mipsPkg::dmemWords)+1:2];

	//////////////////////////////
	// Clocked write
	//////////////////////////////
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < mipsPkg::dmemWords; i++) begin
				mem[i] <= '0; // Start from clean memory
			end
		end else if (wrEn) begin
			mem[wordIdx] <= wrData;
		end
	end

	// Asynchronous read, lw completes in the same cycle
	assign rdData = mem[wordIdx];

endmodule

//--- src/mipsCore.sv
`timescale 1ns/100ps

module mipsCore (
	input  logic           clk,
	input  logic           arstN,
	input  logic [31:0]    instr,  // From instruction memory, indexed by pc
	output logic [31:0]    pc,
	output mipsPkg::regWbT regWb,  // Register commit this cycle
	output mipsPkg::memWrT memWr   // Store commit this cycle
);

	mipsPkg::ctrlT ctrl;

	logic        judge;
	logic [31:0] pcPlus4;
	logic [31:0] rsData;
	logic [31:0] rtData;
	logic [31:0] aluY;
	logic [31:0] rdData;
	logic [4:0]  wrAddr;
	logic [31:0] wrData;

	//////////////////////////////
	// Decode
	//////////////////////////////
	ctrlDecode i_ctrlDecode (
		.instr (instr),
		.judge (judge),
		.ctrl  (ctrl)
	);

	//////////////////////////////
	// Register file
	//////////////////////////////
	regFile i_regFile (
		.clk    (clk),
		.arstN  (arstN),
		.rsAddr (instr[25:21]),
		.rtAddr (instr[20:16]),
		.wrAddr (wrAddr),
		.wrData (wrData),
		.wrEn   (ctrl.regWrite), // $0 filtered inside
		.rsData (rsData),
		.rtData (rtData)
	);

	//////////////////////////////
	// Execute and memory
	//////////////////////////////
	aluUnit i_aluUnit (
		.ctrl   (ctrl),
		.rsData (rsData),
		.rtData (rtData),
		.imm16  (instr[15:0]),
		.aluY   (aluY)
	);

	nextPc i_nextPc (
		.clk     (clk),
		.arstN   (arstN),
		.instr   (instr),
		.ctrl    (ctrl),
		.rsData  (rsData),
		.rtData  (rtData),
		.pc      (pc),
		.pcPlus4 (pcPlus4),
		.judge   (judge)
	);

	dataMem i_dataMem (
		.clk    (clk),
		.arstN  (arstN),
		.addr   (aluY),   // rs + offset
		.wrData (rtData),
		.wrEn   (ctrl.memWrite),
		.rdData (rdData)
	);

	//////////////////////////////
	// Write-back select
	//////////////////////////////
	always_comb begin
		case (ctrl.regDst)
			mipsPkg::dstRd:   wrAddr = instr[15:11];
			mipsPkg::dstLink: wrAddr = mipsPkg::linkReg; // jal, bltzal
			default:          wrAddr = instr[20:16];     // rt
		endcase
	end

	always_comb begin
		case (ctrl.wbSel)
			mipsPkg::wbMem:  wrData = rdData;
			mipsPkg::wbLink: wrData = pcPlus4; // Return address
			default:         wrData = aluY;
		endcase
	end

	// Commit reports, $0 writes shown as no write
	assign regWb.en   = ctrl.regWrite && (wrAddr != 5'd0);
	assign regWb.addr = wrAddr;
	assign regWb.data = wrData;

	assign memWr.en   = ctrl.memWrite;
	assign memWr.addr = aluY;
	assign memWr.data = rtData;

endmodule

//--- src/mipsPkg.sv
package mipsPkg;

	//////////////////////////////
	// Core constants
	//////////////////////////////
	localparam logic [31:0] resetPc   = 32'h0000_3000; // First fetch after reset
	localparam int          dmemWords = 256;           // Data memory depth in words
	localparam logic [4:0]  linkReg   = 5'd31;         // $ra, target of jal and bltzal

	// Primary opcode field, instr[31:26]
	localparam logic [5:0] opRType  = 6'b000000;
	localparam logic [5:0] opOri    = 6'b001101;
	localparam logic [5:0] opLw     = 6'b100011;
	localparam logic [5:0] opSw     = 6'b101011;
	localparam logic [5:0] opBeq    = 6'b000100;
	localparam logic [5:0] opLui    = 6'b001111;
	localparam logic [5:0] opJ      = 6'b000010;
	localparam logic [5:0] opJal    = 6'b000011;
	localparam logic [5:0] opBltzal = 6'b100111; // Non-standard slot for bltzal

	// Function field of R-type, instr[5:0]
	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnJr  = 6'b001000;

	//////////////////////////////
	// Control encodings
	//////////////////////////////
	typedef enum logic [2:0] {
		aluAdd = 3'b000,
		aluSub = 3'b001,
		aluOr  = 3'b010,
		aluLui = 3'b101  // Operand B shifted up 16
	} aluOpE;

	typedef enum logic [2:0] {
		npcSeq    = 3'b000, // pc + 4
		npcJump   = 3'b001, // j and jal
		npcBeq    = 3'b010,
		npcJr     = 3'b011,
		npcBltzal = 3'b100
	} npcOpE;

	typedef enum logic [1:0] {
		dstRt   = 2'b00,
		dstRd   = 2'b01,
		dstLink = 2'b10
	} regDstE;

	typedef enum logic [1:0] {
		wbAlu  = 2'b00,
		wbMem  = 2'b01,
		wbLink = 2'b10  // Return address pc + 4
	} wbSelE;

	// Decoder output, one bundle per instruction
	typedef struct packed {
		regDstE regDst;
		logic   regWrite;
		logic   extSigned; // Sign extend imm16
		logic   aluSrcImm; // ALU operand B from immediate
		aluOpE  aluOp;
		logic   memWrite;
		wbSelE  wbSel;
		npcOpE  npcOp;
	} ctrlT;

	//////////////////////////////
	// Commit reports
	//////////////////////////////
	typedef struct packed {
		logic        en;
		logic [4:0]  addr;
		logic [31:0] data;
	} regWbT;

	typedef struct packed {
		logic        en;
		logic [31:0] addr; // Byte address
		logic [31:0] data;
	} memWrT;

endpackage

//--- src/nextPc.sv
`timescale 1ns/100ps

module nextPc (
	input  logic          clk,
	input  logic          arstN,
	input  logic [31:0]   instr,
	input  mipsPkg::ctrlT ctrl,
	input  logic [31:0]   rsData,
	input  logic [31:0]   rtData,
	output logic [31:0]   pc,
	output logic [31:0]   pcPlus4,
	output logic          judge
);

	logic [31:0] branchTarget; // pc + 4 + (offset << 2)
	logic [31:0] jumpTarget;   // Region of pc + 4 with 26-bit index
	logic        beqTaken;
	logic [31:0] npc;

	//////////////////////////////
	// Targets and compare
	//////////////////////////////
	assign pcPlus4      = pc + 32'd4;
	assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
	assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};

	assign beqTaken = (rsData == rtData);
	assign judge    = rsData[31]; // rs < 0, bltzal condition

	//////////////////////////////
	// Next pc select
	//////////////////////////////
	always_comb begin
		case (ctrl.npcOp)
			mipsPkg::npcSeq:    npc = pcPlus4;
			mipsPkg::npcJump:   npc = jumpTarget;
			mipsPkg::npcBeq:    npc = beqTaken ? branchTarget : pcPlus4;
			mipsPkg::npcJr:     npc = rsData;                         // Return via rs
			mipsPkg::npcBltzal: npc = judge ? branchTarget : pcPlus4; // Falls through when rs >= 0
			default:            npc = pcPlus4;
		endcase
	end

	// pc register, one instruction retired per edge
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= mipsPkg::resetPc;
		end else begin
			pc <= npc;
		end
	end

endmodule

//--- src/regFile.sv
`timescale 1ns/100ps

module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic [4:0]  rsAddr,
	input  logic [4:0]  rtAddr,
	input  logic [4:0]  wrAddr,
	input  logic [31:0] wrData,
	input  logic        wrEn,
	output logic [31:0] rsData,
	output logic [31:0] rtData
);

	logic [31:0] regs [32]; // GPR array, $0 included but never written

	//////////////////////////////
	// Write port
	//////////////////////////////
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != 5'd0)) begin // $0 writes dropped
			regs[wrAddr] <= wrData;
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////
	// No write bypass, old value seen in the writing cycle
	always_comb begin
		if (rsAddr == 5'd0) begin
			rsData = '0;
		end else begin
			rsData = regs[rsAddr];
		end
	end

	always_comb begin
		if (rtAddr == 5'd0) begin
			rtData = '0;
		end else begin
			rtData = regs[rtAddr];
		end
	end

endmodule

//--- verif/corePatterns.txt
// pc       instr    wbEn wbAddr wbData   memEn memAddr  memData
// One line per committed instruction in execution order, all fields hex
00003000 3C018000 1 01 80000000 0 00000000 00000000
00003004 34210001 1 01 80000001 0 00000000 00000000
00003008 00211820 1 03 00000002 0 00000000 00000000
0000300C 34020005 1 02 00000005 0 00000000 00000000
00003010 00022022 1 04 FFFFFFFB 0 00000000 00000000
00003014 00620020 0 00 00000000 0 00000000 00000000
00003018 00032820 1 05 00000002 0 00000000 00000000
0000301C 34060100 1 06 00000100 0 00000000 00000000
00003020 ACC10008 0 00 00000000 1 00000108 80000001
00003024 ACC4FFFC 0 00 00000000 1 000000FC FFFFFFFB
00003028 8CC70008 1 07 80000001 0 00000000 00000000
0000302C 8CC8FFFC 1 08 FFFFFFFB 0 00000000 00000000
00003030 10E10002 0 00 00000000 0 00000000 00000000
0000303C 10E80005 0 00 00000000 0 00000000 00000000
00003040 08000C14 0 00 00000000 0 00000000 00000000
00003050 0C000C18 1 1F 00003054 0 00000000 00000000
00003060 9C800003 1 1F 00003064 0 00000000 00000000
00003070 9C400003 0 00 00000000 0 00000000 00000000
00003074 FC000000 0 00 00000000 0 00000000 00000000
00003078 03E00008 0 00 00000000 0 00000000 00000000
00003064 340900AA 1 09 000000AA 0 00000000 00000000
00003068 00000000 0 00 00000000 0 00000000 00000000

//--- verif/mipsCore_sva.sv
`timescale 1ns/100ps

module mipsCoreSva (
	input logic           clk,
	input logic           arstN,
	input logic [31:0]    pc,
	input mipsPkg::regWbT regWb,
	input mipsPkg::memWrT memWr
);

	// Fetch address on a word boundary
	property pcAligned;
		@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00;
	endproperty

	// First edge after reset release still sees the reset pc
	property pcAfterReset;
		@(posedge clk) $rose(arstN) |-> (pc == mipsPkg::resetPc);
	endproperty

	// One commit kind per instruction
	property wbMemExclusive;
		@(posedge clk) disable iff (!arstN) !(regWb.en && memWr.en);
	endproperty

	assertPcAligned:  assert property (pcAligned) else $error("pc %h not word aligned", pc);
	assertResetPc:    assert property (pcAfterReset) else $error("pc %h after reset", pc);
	assertExclusive:  assert property (wbMemExclusive) else $error("regWb and memWr both high");

endmodule

//--- verif/tbMipsCore.sv
`timescale 1ns/100ps

module tbMipsCore;

	localparam int  numPatterns  = 22;        // Lines in the pattern file
	localparam int  fieldsPerPat = 8;         // pc, instr, regWb x3, memWr x3
	localparam int  resetCycles  = 4;
	localparam int  cycleLimit   = numPatterns + resetCycles + 20;
	localparam time clkHalf      = 10;        // 20 ns period
	localparam time driveDelay   = 1;         // After rising edge
	localparam time sampleDelay  = 17;        // Lands 2 ns before next edge

	logic           clk;
	logic           arstN;
	logic [31:0]    instr;
	logic [31:0]    pc;
	mipsPkg::regWbT regWb;
	mipsPkg::memWrT memWr;

	logic [31:0] patMem [numPatterns*fieldsPerPat]; // Flat, 8 words per entry
	int          errorCount;
	int          checkCount;
	int          cycleCount;
	bit          runDone;

	mipsCore i_dut (
		.clk   (clk),
		.arstN (arstN),
		.instr (instr),
		.pc    (pc),
		.regWb (regWb),
		.memWr (memWr)
	);

	bind mipsCore mipsCoreSva i_sva (
		.clk   (clk),
		.arstN (arstN),
		.pc    (pc),
		.regWb (regWb),
		.memWr (memWr)
	);

	//////////////////////////////
	// Clock and watchdog
	//////////////////////////////
	initial clk = 1'b0;
	always #clkHalf clk = ~clk;

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if ((cycleCount >= cycleLimit) && !runDone) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Compare helpers
	//////////////////////////////
	task automatic compareField(input int idx, input string name,
			input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("CHECK FAILED at %0t: entry %0d %s is %h, expected %h",
				$time, idx, name, got, exp);
		end
	endtask

	// addr and data only matter when the enable is expected high
	task automatic checkCommit(input int idx);
		int base;
		base = idx * fieldsPerPat;
		compareField(idx, "pc", pc, patMem[base]);
		compareField(idx, "regWb.en", {31'd0, regWb.en}, patMem[base+2]);
		if (patMem[base+2][0]) begin
			compareField(idx, "regWb.addr", {27'd0, regWb.addr}, patMem[base+3]);
			compareField(idx, "regWb.data", regWb.data, patMem[base+4]);
		end
		compareField(idx, "memWr.en", {31'd0, memWr.en}, patMem[base+5]);
		if (patMem[base+5][0]) begin
			compareField(idx, "memWr.addr", memWr.addr, patMem[base+6]);
			compareField(idx, "memWr.data", memWr.data, patMem[base+7]);
		end
	endtask

	//////////////////////////////
	// Stimulus and checks
	//////////////////////////////
	initial begin
		errorCount = 0;
		checkCount = 0;
		cycleCount = 0;
		runDone    = 1'b0;
		arstN      = 1'b0; // Reset from time zero
		instr      = '0;
		$readmemh("verif/corePatterns.txt", patMem);

		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		arstN = 1'b1;

		// Serve one instruction per cycle in execution order
		for (int k = 0; k < numPatterns; k++) begin
			instr = patMem[k*fieldsPerPat + 1];
			#sampleDelay;
			checkCommit(k); // Outputs settled, edge not yet reached
			@(posedge clk);
			#driveDelay;
		end
		runDone = 1'b1;

		$display("Checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
